// File: src/harness_params.svh
`ifndef HARNESS_PARAMS_SVH
`define HARNESS_PARAMS_SVH

// core data and address width
`define XLEN 32

// one write enable per byte of a word
`define BYTE_LANES 4

// cycle counter and success streak width
`define CYCLE_W 32

// matching cycles of final value before the run is stopped
`define SUCCESS_HOLD 30

// data memory: grant after 4 cycles, read data valid after 8
`define DMEM_GNT_LAT 4
`define DMEM_RVALID_LAT 8

// instruction memory: grant in the same cycle, read data one cycle later
`define IMEM_GNT_LAT 0
`define IMEM_RVALID_LAT 1

`endif

// File: src/harness_pkg.sv
`include "harness_params.svh"

package harness_pkg;

    // GPIO control word fields
    typedef struct packed {
        logic [`XLEN-3:0] reserved;
        logic             soft_reset;
        logic             start;
    } ctrl_fields_t;

    // edge detector works on raw bits, run control on named fields
    typedef union packed {
        logic [`XLEN-1:0] raw;
        ctrl_fields_t     fields;
    } ctrl_word_t;

    // request from the core towards a memory
    typedef struct packed {
        logic                   req;
        logic [`XLEN-1:0]       addr;
        logic                   we;
        logic [`BYTE_LANES-1:0] be;
        logic [`XLEN-1:0]       wdata;
    } mem_req_t;

    // response back to the core
    typedef struct packed {
        logic [`XLEN-1:0] rdata;
        logic             rvalid;
        logic             gnt;
    } mem_rsp_t;

    // BRAM port B pins, clock and reset excluded
    typedef struct packed {
        logic                   en;
        logic [`BYTE_LANES-1:0] web;
        logic [`XLEN-1:0]       addr;
        logic [`XLEN-1:0]       din;
    } bram_port_t;

endpackage

// File: src/ctrl_pulse_gen.sv
module ctrl_pulse_gen
    import harness_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  ctrl_word_t ctrl_i,
    output ctrl_word_t pulse_o
);

    // control word as seen at the previous edge
    logic [$bits(ctrl_word_t)-1:0] prev_q;
    logic [$bits(ctrl_word_t)-1:0] pulse_q;
    logic [$bits(ctrl_word_t)-1:0] rise;

    // 0 to 1 transitions, bit by bit
    assign rise = ctrl_i.raw & ~prev_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_q  <= '0;
            pulse_q <= '0;
        end else begin
            prev_q  <= ctrl_i.raw;
            pulse_q <= rise;
        end
    end

    // a bit already high when reset drops still gives one pulse
    assign pulse_o.raw = pulse_q;

endmodule

// File: src/run_controller.sv
`include "harness_params.svh"

module run_controller
    import harness_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  ctrl_word_t          pulse_i,
    input  logic [`XLEN-1:0]    final_value_i,
    input  logic [`XLEN-1:0]    success_code_i,
    output logic                run_enable_o,
    output logic                stop_o,
    output logic [`CYCLE_W-1:0] cycle_count_o
);

    logic                enable_q;
    logic                stop_q;
    logic [`CYCLE_W-1:0] cycle_q;
    logic [`CYCLE_W-1:0] streak_q;
    logic                clear;
    logic                match;
    logic                hold_met;

    // hard reset or the soft reset pulse from GPIO
    assign clear = reset | pulse_i.fields.soft_reset;

    assign match    = (final_value_i == success_code_i);
    assign hold_met = (streak_q >= `CYCLE_W'(`SUCCESS_HOLD));

    // start restarts the count, otherwise count while enabled
    always_ff @(posedge clk) begin
        if (clear) begin
            enable_q <= 1'b0;
            cycle_q  <= '0;
        end else if (pulse_i.fields.start) begin
            enable_q <= 1'b1;
            cycle_q  <= '0;
        end else if (enable_q) begin
            cycle_q  <= cycle_q + 1'b1;
        end
    end

    // matches are counted even before the run is enabled,
    // and they need not be back to back
    always_ff @(posedge clk) begin
        if (clear) begin
            streak_q <= '0;
        end else if (match) begin
            streak_q <= streak_q + 1'b1;
        end
    end

    // sticky stop, one edge after the streak reaches the hold count
    always_ff @(posedge clk) begin
        if (clear) begin
            stop_q <= 1'b0;
        end else if (hold_met) begin
            stop_q <= 1'b1;
        end
    end

    assign run_enable_o  = enable_q & ~stop_q;
    assign stop_o        = stop_q;
    assign cycle_count_o = cycle_q;

endmodule

// File: src/bram_bridge.sv
`include "harness_params.svh"

module bram_bridge
    import harness_pkg::*;
#(
    parameter int GNT_LAT    = 4,
    parameter int RVALID_LAT = 8,
    parameter bit WRITABLE   = 1'b1
) (
    input  logic             clk,
    input  logic             reset,
    input  mem_req_t         req_i,
    input  logic [`XLEN-1:0] dout_i,
    output mem_rsp_t         rsp_o,
    output bram_port_t       bram_o
);

    // longest delay needed, at least one stage so the line exists
    localparam int MAX_LAT = (GNT_LAT > RVALID_LAT) ? GNT_LAT : RVALID_LAT;
    localparam int DEPTH   = (MAX_LAT > 0) ? MAX_LAT : 1;

    // req_line[i] holds req from i+1 cycles ago
    logic [DEPTH-1:0] req_line;
    // taps[n] is req delayed by n cycles, taps[0] the live request
    logic [DEPTH:0]   taps;

    assign taps = {req_line, req_i.req};

    // one new entry per cycle, no back-pressure
    always_ff @(posedge clk) begin
        if (reset) begin
            req_line <= '0;
        end else begin
            req_line <= taps[DEPTH-1:0];
        end
    end

    // latency 0 taps the live request, so gnt is combinational
    assign rsp_o.gnt    = taps[GNT_LAT];
    assign rsp_o.rvalid = taps[RVALID_LAT];
    assign rsp_o.rdata  = dout_i;

    // BRAM port follows the request in the same cycle
    always_comb begin
        bram_o.en   = req_i.req;
        bram_o.addr = req_i.addr;
        if (WRITABLE) begin
            bram_o.web = req_i.we ? req_i.be : '0;
            bram_o.din = req_i.wdata;
        end else begin
            // read-only port never writes
            bram_o.web = '0;
            bram_o.din = '0;
        end
    end

endmodule

// File: src/core_harness_top.sv
`include "harness_params.svh"

module core_harness_top
    import harness_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    // GPIO from the board
    input  ctrl_word_t          ctrl_word_i,
    input  logic [`XLEN-1:0]    success_code_i,

    // external RV32I core
    input  logic [`XLEN-1:0]    final_value_i,
    input  mem_req_t            dmem_req_i,
    input  mem_req_t            imem_req_i,
    output logic                core_reset_o,
    output logic                run_enable_o,
    output mem_rsp_t            dmem_rsp_o,
    output mem_rsp_t            imem_rsp_o,

    // run status
    output logic                stop_o,
    output logic [`CYCLE_W-1:0] cycle_count_o,

    // BRAM port B of data and instruction memory
    output bram_port_t          dmem_bram_o,
    input  logic [`XLEN-1:0]    dmem_dout_i,
    output bram_port_t          imem_bram_o,
    input  logic [`XLEN-1:0]    imem_dout_i
);

    ctrl_word_t ctrl_pulse;
    logic       core_reset;

    // rising edges of the GPIO control word
    ctrl_pulse_gen u_ctrl_pulse_gen (
        .clk     (clk),
        .reset   (reset),
        .ctrl_i  (ctrl_word_i),
        .pulse_o (ctrl_pulse)
    );

    // core and bridges restart on either reset source
    assign core_reset   = reset | ctrl_pulse.fields.soft_reset;
    assign core_reset_o = core_reset;

    run_controller u_run_controller (
        .clk            (clk),
        .reset          (reset),
        .pulse_i        (ctrl_pulse),
        .final_value_i  (final_value_i),
        .success_code_i (success_code_i),
        .run_enable_o   (run_enable_o),
        .stop_o         (stop_o),
        .cycle_count_o  (cycle_count_o)
    );

    // data memory, writable
    bram_bridge #(
        .GNT_LAT    (`DMEM_GNT_LAT),
        .RVALID_LAT (`DMEM_RVALID_LAT),
        .WRITABLE   (1'b1)
    ) u_dmem_bridge (
        .clk    (clk),
        .reset  (core_reset),
        .req_i  (dmem_req_i),
        .dout_i (dmem_dout_i),
        .rsp_o  (dmem_rsp_o),
        .bram_o (dmem_bram_o)
    );

    // instruction memory, read only
    bram_bridge #(
        .GNT_LAT    (`IMEM_GNT_LAT),
        .RVALID_LAT (`IMEM_RVALID_LAT),
        .WRITABLE   (1'b0)
    ) u_imem_bridge (
        .clk    (clk),
        .reset  (core_reset),
        .req_i  (imem_req_i),
        .dout_i (imem_dout_i),
        .rsp_o  (imem_rsp_o),
        .bram_o (imem_bram_o)
    );

endmodule

// File: sim/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // free running, first rising edge at half a period
    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: sim/core_harness_props.sv
module core_harness_props (
    input logic clk,
    input logic reset,
    input logic core_reset_i,
    input logic run_enable_i,
    input logic stop_i,
    input logic start_pulse_i
);

    // stop only falls after a cycle with hard or soft reset
    stop_sticky: assert property (
        @(posedge clk) disable iff (reset)
        $fell(stop_i) |-> $past(core_reset_i)
    ) else $error("stop_o fell without a reset");

    // run only starts one edge after a start pulse
    enable_from_start: assert property (
        @(posedge clk) disable iff (reset)
        $rose(run_enable_i) |-> $past(start_pulse_i)
    ) else $error("run_enable_o rose without a start pulse");

    // soft reset pulse is one cycle wide
    soft_reset_width: assert property (
        @(posedge clk) disable iff (reset)
        core_reset_i |=> !core_reset_i
    ) else $error("core_reset_o longer than one cycle");

endmodule

bind core_harness_top core_harness_props props_i (
    .clk           (clk),
    .reset         (reset),
    .core_reset_i  (core_reset_o),
    .run_enable_i  (run_enable_o),
    .stop_i        (stop_o),
    .start_pulse_i (ctrl_pulse.fields.start)
);

// File: sim/core_harness_tb.sv
`include "harness_params.svh"

module core_harness_tb
    import harness_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int MARGIN       = 64;
    localparam logic [`XLEN-1:0] MAGIC = 32'h00c0ffee;

    typedef struct packed {
        logic [`XLEN-1:0]    ctrl;
        logic [`XLEN-1:0]    final_value;
        logic [`XLEN-1:0]    success_code;
        logic [7:0]          len;
        logic                exp_enable;
        logic                exp_stop;
        logic [`CYCLE_W-1:0] exp_count;
    } row_t;

    logic                clk;
    logic                reset;
    ctrl_word_t          ctrl_word_i;
    logic [`XLEN-1:0]    success_code_i;
    logic [`XLEN-1:0]    final_value_i;
    mem_req_t            dmem_req_i;
    mem_req_t            imem_req_i;
    logic [`XLEN-1:0]    dmem_dout_i;
    logic [`XLEN-1:0]    imem_dout_i;
    logic                core_reset_o;
    logic                run_enable_o;
    logic                stop_o;
    logic [`CYCLE_W-1:0] cycle_count_o;
    mem_rsp_t            dmem_rsp_o;
    mem_rsp_t            imem_rsp_o;
    bram_port_t          dmem_bram_o;
    bram_port_t          imem_bram_o;

    row_t     rows[$];
    // hist[k] is the request driven k cycles ago
    mem_req_t dmem_hist[0:8];
    mem_req_t imem_hist[0:8];
    logic     exp_crst;
    logic     soft_last;
    logic     soft_prev;
    int       cycles;
    int       limit;

    clk_gen #(.PERIOD(20)) clk_gen_i (.clk_o(clk));

    core_harness_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .ctrl_word_i    (ctrl_word_i),
        .success_code_i (success_code_i),
        .final_value_i  (final_value_i),
        .dmem_req_i     (dmem_req_i),
        .imem_req_i     (imem_req_i),
        .core_reset_o   (core_reset_o),
        .run_enable_o   (run_enable_o),
        .dmem_rsp_o     (dmem_rsp_o),
        .imem_rsp_o     (imem_rsp_o),
        .stop_o         (stop_o),
        .cycle_count_o  (cycle_count_o),
        .dmem_bram_o    (dmem_bram_o),
        .dmem_dout_i    (dmem_dout_i),
        .imem_bram_o    (imem_bram_o),
        .imem_dout_i    (imem_dout_i)
    );

    task automatic fail_now(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("%s got %b expected %b", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [`CYCLE_W-1:0] got,
                               input logic [`CYCLE_W-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("%s got %0d expected %0d", name, got, exp));
        end
    endtask

    task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
        if (got !== exp) begin
            fail_now($sformatf("%s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bram(input string name, input bram_port_t got,
                              input bram_port_t exp);
        if (got !== exp) begin
            fail_now($sformatf("%s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic add_row(input logic [`XLEN-1:0] ctrl, input logic [`XLEN-1:0] fin,
                           input logic [`XLEN-1:0] code, input int len, input logic en,
                           input logic stop, input int count);
        row_t r;
        r.ctrl         = ctrl;
        r.final_value  = fin;
        r.success_code = code;
        r.len          = len[7:0];
        r.exp_enable   = en;
        r.exp_stop     = stop;
        r.exp_count    = count;
        rows.push_back(r);
    endtask

    function automatic mem_req_t random_req();
        mem_req_t q;
        q.req   = $urandom % 2;
        q.addr  = $urandom;
        q.we    = $urandom % 2;
        q.be    = $urandom;
        q.wdata = $urandom;
        return q;
    endfunction

    // one clock cycle of a row with bridge and reset checks
    task automatic run_cycle(input row_t r);
        mem_req_t   dreq;
        mem_req_t   ireq;
        mem_rsp_t   exp_rsp;
        bram_port_t exp_bram;
        @(posedge clk);
        // bridge delay lines clear on a reset in the cycle just ended
        if (exp_crst) begin
            for (int i = 0; i <= 8; i++) begin
                dmem_hist[i].req = 1'b0;
                imem_hist[i].req = 1'b0;
            end
        end
        for (int i = 8; i > 0; i--) begin
            dmem_hist[i] = dmem_hist[i-1];
            imem_hist[i] = imem_hist[i-1];
        end
        dreq = random_req();
        ireq = random_req();
        dmem_hist[0] = dreq;
        imem_hist[0] = ireq;
        reset          <= 1'b0;
        ctrl_word_i    <= r.ctrl;
        final_value_i  <= r.final_value;
        success_code_i <= r.success_code;
        dmem_req_i     <= dreq;
        imem_req_i     <= ireq;
        dmem_dout_i    <= $urandom;
        imem_dout_i    <= $urandom;
        // soft reset pulse one edge after a rising bit
        exp_crst  = soft_last & ~soft_prev;
        soft_prev = soft_last;
        soft_last = r.ctrl[1];
        @(negedge clk);
        check_flag("core_reset_o", core_reset_o, exp_crst);
        exp_bram.en   = dreq.req;
        exp_bram.addr = dreq.addr;
        exp_bram.web  = dreq.we ? dreq.be : '0;
        exp_bram.din  = dreq.wdata;
        check_bram("dmem_bram_o", dmem_bram_o, exp_bram);
        exp_rsp.rdata  = dmem_dout_i;
        exp_rsp.gnt    = dmem_hist[4].req;
        exp_rsp.rvalid = dmem_hist[8].req;
        check_rsp("dmem_rsp_o", dmem_rsp_o, exp_rsp);
        exp_bram.en   = ireq.req;
        exp_bram.addr = ireq.addr;
        exp_bram.web  = '0;
        exp_bram.din  = '0;
        check_bram("imem_bram_o", imem_bram_o, exp_bram);
        exp_rsp.rdata  = imem_dout_i;
        exp_rsp.gnt    = imem_hist[0].req;
        exp_rsp.rvalid = imem_hist[1].req;
        check_rsp("imem_rsp_o", imem_rsp_o, exp_rsp);
    endtask

    task automatic fill_table();
        add_row(32'd0, 32'd0, 32'd5, 4, 1'b0, 1'b0, 0);
        // start rises and enable follows two edges later
        add_row(32'd1, 32'd0, 32'd5, 2, 1'b0, 1'b0, 0);
        add_row(32'd1, 32'd0, 32'd5, 1, 1'b1, 1'b0, 0);
        add_row(32'd1, 32'd0, 32'd5, 1, 1'b1, 1'b0, 1);
        add_row(32'd1, 32'd0, 32'd5, 1, 1'b1, 1'b0, 2);
        add_row(32'd1, 32'd0, 32'd5, 5, 1'b1, 1'b0, 7);
        add_row(32'd0, 32'd0, 32'd5, 2, 1'b1, 1'b0, 9);
        // second rising edge of start restarts the count
        add_row(32'd1, 32'd0, 32'd5, 2, 1'b1, 1'b0, 11);
        add_row(32'd1, 32'd0, 32'd5, 1, 1'b1, 1'b0, 0);
        add_row(32'd1, 32'd0, 32'd5, 3, 1'b1, 1'b0, 3);
        // soft reset rises while start is held
        add_row(32'd3, 32'd0, 32'd5, 2, 1'b1, 1'b0, 5);
        add_row(32'd3, 32'd0, 32'd5, 1, 1'b0, 1'b0, 0);
        add_row(32'd3, 32'd0, 32'd5, 4, 1'b0, 1'b0, 0);
        add_row(32'd0, 32'd0, 32'd5, 1, 1'b0, 1'b0, 0);
        add_row(32'd1, 32'd0, 32'd5, 2, 1'b0, 1'b0, 0);
        add_row(32'd1, 32'd0, 32'd5, 1, 1'b1, 1'b0, 0);
        // 29 matches, a gap, then the 30th match
        add_row(32'd1, MAGIC, MAGIC, 29, 1'b1, 1'b0, 29);
        add_row(32'd1, 32'd0, 32'd5, 3, 1'b1, 1'b0, 32);
        add_row(32'd1, MAGIC, MAGIC, 1, 1'b1, 1'b0, 33);
        add_row(32'd1, 32'd0, 32'd5, 1, 1'b1, 1'b0, 34);
        add_row(32'd1, 32'd0, 32'd5, 1, 1'b0, 1'b1, 35);
        add_row(32'd1, 32'd0, 32'd5, 5, 1'b0, 1'b1, 40);
        // soft reset clears stop
        add_row(32'd2, 32'd0, 32'd5, 2, 1'b0, 1'b1, 42);
        add_row(32'd2, 32'd0, 32'd5, 1, 1'b0, 1'b0, 0);
        add_row(32'd0, 32'd0, 32'd5, 10, 1'b0, 1'b0, 0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    initial begin
        mem_rsp_t zero_rsp;
        void'($urandom(32'h17d7cd3b));
        cycles         = 0;
        limit          = 0;
        reset          = 1'b1;
        ctrl_word_i    = '0;
        success_code_i = 32'd5;
        final_value_i  = '0;
        dmem_req_i     = '0;
        imem_req_i     = '0;
        dmem_dout_i    = '0;
        imem_dout_i    = '0;
        for (int i = 0; i <= 8; i++) begin
            dmem_hist[i] = '0;
            imem_hist[i] = '0;
        end
        exp_crst  = 1'b1;
        soft_last = 1'b0;
        soft_prev = 1'b0;
        fill_table();
        limit = RESET_CYCLES + MARGIN;
        foreach (rows[i]) begin
            limit += rows[i].len;
        end

        // reset state
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        zero_rsp = '0;
        check_flag("core_reset_o", core_reset_o, 1'b1);
        check_flag("stop_o", stop_o, 1'b0);
        check_flag("run_enable_o", run_enable_o, 1'b0);
        check_count("cycle_count_o", cycle_count_o, '0);
        check_rsp("dmem_rsp_o", dmem_rsp_o, zero_rsp);
        check_rsp("imem_rsp_o", imem_rsp_o, zero_rsp);

        foreach (rows[i]) begin
            for (int c = 0; c < rows[i].len; c++) begin
                run_cycle(rows[i]);
            end
            check_flag($sformatf("row %0d run_enable_o", i), run_enable_o,
                       rows[i].exp_enable);
            check_flag($sformatf("row %0d stop_o", i), stop_o, rows[i].exp_stop);
            check_count($sformatf("row %0d cycle_count_o", i), cycle_count_o,
                        rows[i].exp_count);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/harness_pkg.sv
src/ctrl_pulse_gen.sv
src/run_controller.sv
src/bram_bridge.sv
src/core_harness_top.sv
sim/clk_gen.sv
sim/core_harness_props.sv
sim/core_harness_tb.sv

// File: Bender.yml
package:
  name: core_harness

sources:
  - include_dirs:
      - src
    files:
      - src/harness_pkg.sv
      - src/ctrl_pulse_gen.sv
      - src/run_controller.sv
      - src/bram_bridge.sv
      - src/core_harness_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/clk_gen.sv
      - sim/core_harness_props.sv
      - sim/core_harness_tb.sv
